// File: src/mem_sys_params.svh
`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

// Core data and address width
`define DATA_BITS       32

// Cache geometry, 16 lines of 4 words
`define LINE_WORDS      4
`define INDEX_BITS      4

// AXI field widths
`define AXI_ID_BITS     4
`define AXI_LEN_BITS    8
`define AXI_STRB_BITS   4
`define AXI_RESP_BITS   2

// AXI encodings
`define AXI_LEN_ONE     8'd0
`define AXI_LEN_FOUR    8'd3
`define AXI_SIZE_WORD   3'd2
`define AXI_BURST_INCR  2'd1

// Address bit that bypasses the cache
`define UNCACHED_BIT    31

`endif

// File: src/mem_sys_pkg.sv
`default_nettype none

`include "mem_sys_params.svh"

package mem_sys_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        AR_CH = 3'd1,
        R_CH  = 3'd2,
        AW_CH = 3'd3,
        W_CH  = 3'd4,
        B_CH  = 3'd5
    } master_state_e;

    // Byte lanes touched by an access of this size at this offset
    function automatic logic [`AXI_STRB_BITS-1:0] byte_lanes(access_size_e size,
                                                            logic [1:0] ofs);
        case (size)
            SIZE_BYTE: return `AXI_STRB_BITS'(1) << ofs;
            SIZE_HALF: return `AXI_STRB_BITS'(3) << {ofs[1], 1'b0};
            default:   return '1;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: src/cache_bus_if.sv
`default_nettype none

`include "mem_sys_params.svh"

interface cache_bus_if
    import mem_sys_pkg::*;
();

    // Cache to master, held until done
    logic                  rreq;
    logic                  wreq;
    logic                  single;
    logic [`DATA_BITS-1:0] addr;
    logic [`DATA_BITS-1:0] wdata;
    access_size_e          size;

    // Master to cache
    logic [`DATA_BITS-1:0] rdata;
    logic                  rbeat;
    logic                  rlast;
    logic                  done;

    modport cache (
        output rreq, wreq, single, addr, wdata, size,
        input  rdata, rbeat, rlast, done
    );

    modport master (
        input  rreq, wreq, single, addr, wdata, size,
        output rdata, rbeat, rlast, done
    );

endinterface

`default_nettype wire

// File: src/dcache.sv
`default_nettype none

`include "mem_sys_params.svh"

module dcache
    import mem_sys_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_i,
    input  wire                      we_i,
    input  wire [`DATA_BITS-1:0]     addr_i,
    input  wire [`DATA_BITS-1:0]     wdata_i,
    input  wire access_size_e        size_i,
    output logic [`DATA_BITS-1:0]    rdata_o,
    output logic                     stall_o,
    cache_bus_if.cache               bus
);

    localparam int LINES     = 1 << `INDEX_BITS;
    localparam int WORD_BITS = $clog2(`LINE_WORDS);
    localparam int OFS_BITS  = $clog2(`AXI_STRB_BITS);
    localparam int LINE_OFS  = WORD_BITS + OFS_BITS;
    localparam int TAG_BITS  = `DATA_BITS - `INDEX_BITS - LINE_OFS;

    // Line store
    logic [`DATA_BITS-1:0]     line_data [LINES][`LINE_WORDS];
    logic [TAG_BITS-1:0]       line_tag  [LINES];
    logic [LINES-1:0]          line_valid;

    logic [TAG_BITS-1:0]       tag;
    logic [`INDEX_BITS-1:0]    index;
    logic [WORD_BITS-1:0]      word;
    logic                      cached;
    logic                      hit;
    logic                      fin;
    logic                      fill_beat;
    logic [WORD_BITS-1:0]      fill_cnt;
    logic [`DATA_BITS-1:0]     uncached_q;
    logic [`AXI_STRB_BITS-1:0] lanes;
    logic [`DATA_BITS-1:0]     wdata_lane;

    // Address split
    assign tag    = addr_i[`DATA_BITS-1 -: TAG_BITS];
    assign index  = addr_i[LINE_OFS +: `INDEX_BITS];
    assign word   = addr_i[OFS_BITS +: WORD_BITS];
    assign cached = !addr_i[`UNCACHED_BIT];
    assign hit    = cached && line_valid[index] && (line_tag[index] == tag);

    // Store data moved onto its byte lanes
    assign lanes      = byte_lanes(size_i, addr_i[OFS_BITS-1:0]);
    assign wdata_lane = wdata_i << {addr_i[OFS_BITS-1:0], 3'b000};

    // Core side, fin lets the access retire the cycle after done
    assign stall_o = req_i && (we_i || !hit) && !fin;
    assign rdata_o = cached ? line_data[index][word] : uncached_q;

    // Bus request follows the held core request
    assign bus.rreq   = req_i && !we_i && !hit && !fin;
    assign bus.wreq   = req_i && we_i && !fin;
    assign bus.single = !cached;
    assign bus.wdata  = wdata_lane;
    assign bus.size   = size_i;

    always_comb begin
        if (cached && !we_i) begin
            bus.addr = {addr_i[`DATA_BITS-1:LINE_OFS], {LINE_OFS{1'b0}}};
        end else begin
            bus.addr = addr_i;
        end
    end

    assign fill_beat = bus.rbeat && !bus.single;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_valid <= '0;
            fill_cnt   <= '0;
            fin        <= 1'b0;
        end else begin
            fin <= bus.done;
            // Line stays invalid until its last beat lands
            if (fill_beat) begin
                fill_cnt          <= bus.rlast ? '0 : fill_cnt + 1'b1;
                line_valid[index] <= bus.rlast;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_beat) begin
            line_data[index][fill_cnt] <= bus.rdata;
            if (bus.rlast) begin
                line_tag[index] <= tag;
            end
        end
        if (bus.rbeat && bus.single) begin
            uncached_q <= bus.rdata;
        end
        // Write hit updates the cached copy once the bus write is done
        if (bus.done && bus.wreq && hit) begin
            for (int b = 0; b < `AXI_STRB_BITS; b++) begin
                if (lanes[b]) begin
                    line_data[index][word][8*b +: 8] <= wdata_lane[8*b +: 8];
                end
            end
        end
    end

    // Requests and their address stay up until the master is done
    rreq_held: assert property (@(posedge clk) disable iff (!rst)
        bus.rreq && !bus.done |=> bus.rreq && $stable(bus.addr))
        else $error("dcache: read request dropped before done");

    wreq_held: assert property (@(posedge clk) disable iff (!rst)
        bus.wreq && !bus.done |=> bus.wreq && $stable(bus.addr))
        else $error("dcache: write request dropped before done");

endmodule

`default_nettype wire

// File: src/axi_master.sv
`default_nettype none

`include "mem_sys_params.svh"

module axi_master
    import mem_sys_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    cache_bus_if.master                  bus,
    // Write address channel
    output logic                         awvalid_o,
    input  wire                          awready_i,
    output logic [`DATA_BITS-1:0]        awaddr_o,
    output logic [`AXI_LEN_BITS-1:0]     awlen_o,
    output logic [2:0]                   awsize_o,
    output logic [1:0]                   awburst_o,
    output logic [`AXI_ID_BITS-1:0]      awid_o,
    // Write data channel
    output logic                         wvalid_o,
    input  wire                          wready_i,
    output logic [`DATA_BITS-1:0]        wdata_o,
    output logic [`AXI_STRB_BITS-1:0]    wstrb_o,
    output logic                         wlast_o,
    // Write response channel
    input  wire                          bvalid_i,
    output logic                         bready_o,
    input  wire [`AXI_RESP_BITS-1:0]     bresp_i,
    // Read address channel
    output logic                         arvalid_o,
    input  wire                          arready_i,
    output logic [`DATA_BITS-1:0]        araddr_o,
    output logic [`AXI_LEN_BITS-1:0]     arlen_o,
    output logic [2:0]                   arsize_o,
    output logic [1:0]                   arburst_o,
    output logic [`AXI_ID_BITS-1:0]      arid_o,
    // Read data channel
    input  wire                          rvalid_i,
    output logic                         rready_o,
    input  wire [`DATA_BITS-1:0]         rdata_i,
    input  wire                          rlast_i,
    input  wire [`AXI_RESP_BITS-1:0]     rresp_i
);

    master_state_e state;
    master_state_e next;

    logic arhns;
    logic rhns;
    logic awhns;
    logic whns;
    logic bhns;
    logic rdfin;

    // Handshakes
    assign arhns = arvalid_o && arready_i;
    assign rhns  = rready_o && rvalid_i;
    assign awhns = awvalid_o && awready_i;
    assign whns  = wvalid_o && wready_i;
    assign bhns  = bready_o && bvalid_i;
    assign rdfin = rhns && rlast_i;

    // Request fields come straight from the held cache request
    assign araddr_o  = {bus.addr[`DATA_BITS-1:2], 2'b00};
    assign arlen_o   = bus.single ? `AXI_LEN_ONE : `AXI_LEN_FOUR;
    assign arsize_o  = `AXI_SIZE_WORD;
    assign arburst_o = `AXI_BURST_INCR;
    assign arid_o    = '0;

    assign awaddr_o  = {bus.addr[`DATA_BITS-1:2], 2'b00};
    assign awlen_o   = `AXI_LEN_ONE;
    assign awsize_o  = `AXI_SIZE_WORD;
    assign awburst_o = `AXI_BURST_INCR;
    assign awid_o    = '0;

    assign wdata_o   = bus.wdata;
    assign wstrb_o   = byte_lanes(bus.size, bus.addr[1:0]);
    assign wlast_o   = 1'b1;

    // Back to the cache
    assign bus.rdata = rdata_i;
    assign bus.rbeat = rhns;
    assign bus.rlast = rlast_i;
    assign bus.done  = rdfin || bhns;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            IDLE: begin
                if (bus.rreq) begin
                    next = arhns ? R_CH : AR_CH;
                end else if (bus.wreq) begin
                    next = awhns ? W_CH : AW_CH;
                end
            end
            AR_CH:   next = arhns ? R_CH : AR_CH;
            R_CH:    next = rdfin ? IDLE : R_CH;
            AW_CH:   next = awhns ? W_CH : AW_CH;
            W_CH:    next = whns ? B_CH : W_CH;
            B_CH:    next = bhns ? IDLE : B_CH;
            default: next = IDLE;
        endcase
    end

    // Address valids already rise in IDLE
    always_comb begin
        arvalid_o = 1'b0;
        awvalid_o = 1'b0;
        wvalid_o  = 1'b0;
        rready_o  = 1'b0;
        bready_o  = 1'b0;
        case (state)
            IDLE: begin
                arvalid_o = bus.rreq;
                awvalid_o = bus.wreq;
            end
            AR_CH:   arvalid_o = 1'b1;
            R_CH:    rready_o  = 1'b1;
            AW_CH:   awvalid_o = 1'b1;
            W_CH:    wvalid_o  = 1'b1;
            B_CH:    bready_o  = 1'b1;
            default: ;
        endcase
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else $error("axi_master: ARVALID dropped before ARREADY");

    aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else $error("axi_master: AWVALID dropped before AWREADY");

    rd_wr_excl: assert property (@(posedge clk) disable iff (!rst)
        !(arvalid_o && (awvalid_o || wvalid_o)))
        else $error("axi_master: read and write valids high together");

    // Responses are not acted on, but must be driven by the slave
    resp_known: assert property (@(posedge clk) disable iff (!rst)
        (bhns |-> !$isunknown(bresp_i)) and (rhns |-> !$isunknown(rresp_i)))
        else $error("axi_master: unknown response code");

endmodule

`default_nettype wire

// File: src/mem_sys_top.sv
`default_nettype none

`include "mem_sys_params.svh"

module mem_sys_top
    import mem_sys_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    // Core load/store port
    input  wire                          req_i,
    input  wire                          we_i,
    input  wire [`DATA_BITS-1:0]         addr_i,
    input  wire [`DATA_BITS-1:0]         wdata_i,
    input  wire access_size_e            size_i,
    output logic [`DATA_BITS-1:0]        rdata_o,
    output logic                         stall_o,
    // AXI write address
    output logic                         awvalid_o,
    input  wire                          awready_i,
    output logic [`DATA_BITS-1:0]        awaddr_o,
    output logic [`AXI_LEN_BITS-1:0]     awlen_o,
    output logic [2:0]                   awsize_o,
    output logic [1:0]                   awburst_o,
    output logic [`AXI_ID_BITS-1:0]      awid_o,
    // AXI write data
    output logic                         wvalid_o,
    input  wire                          wready_i,
    output logic [`DATA_BITS-1:0]        wdata_o,
    output logic [`AXI_STRB_BITS-1:0]    wstrb_o,
    output logic                         wlast_o,
    // AXI write response
    input  wire                          bvalid_i,
    output logic                         bready_o,
    input  wire [`AXI_RESP_BITS-1:0]     bresp_i,
    // AXI read address
    output logic                         arvalid_o,
    input  wire                          arready_i,
    output logic [`DATA_BITS-1:0]        araddr_o,
    output logic [`AXI_LEN_BITS-1:0]     arlen_o,
    output logic [2:0]                   arsize_o,
    output logic [1:0]                   arburst_o,
    output logic [`AXI_ID_BITS-1:0]      arid_o,
    // AXI read data
    input  wire                          rvalid_i,
    output logic                         rready_o,
    input  wire [`DATA_BITS-1:0]         rdata_i,
    input  wire                          rlast_i,
    input  wire [`AXI_RESP_BITS-1:0]     rresp_i
);

    cache_bus_if bus ();

    dcache u_dcache (
        .clk     (clk),
        .rst     (rst),
        .req_i   (req_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .size_i  (size_i),
        .rdata_o (rdata_o),
        .stall_o (stall_o),
        .bus     (bus.cache)
    );

    // AXI ports carry the same names as on the master
    axi_master u_axi_master (
        .bus (bus.master),
        .*
    );

endmodule

`default_nettype wire

// File: tb/axi_mem_model.sv
`default_nettype none

`include "mem_sys_params.svh"

module axi_mem_model
    import mem_sys_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          awvalid_i,
    output logic                         awready_o,
    input  wire [`DATA_BITS-1:0]         awaddr_i,
    input  wire                          wvalid_i,
    output logic                         wready_o,
    input  wire [`DATA_BITS-1:0]         wdata_i,
    input  wire [`AXI_STRB_BITS-1:0]     wstrb_i,
    output logic                         bvalid_o,
    input  wire                          bready_i,
    output logic [`AXI_RESP_BITS-1:0]    bresp_o,
    input  wire                          arvalid_i,
    output logic                         arready_o,
    input  wire [`DATA_BITS-1:0]         araddr_i,
    input  wire [`AXI_LEN_BITS-1:0]      arlen_i,
    output logic                         rvalid_o,
    input  wire                          rready_i,
    output logic [`DATA_BITS-1:0]        rdata_o,
    output logic                         rlast_o,
    output logic [`AXI_RESP_BITS-1:0]    rresp_o
);

    // 4 KiB of words
    logic [`DATA_BITS-1:0] mem [1024];

    integer     seed;
    logic [9:0] rd_addr;
    logic [8:0] rd_left;
    logic       r_fire;
    logic [9:0] wr_addr;
    logic       w_pend;
    logic       b_pend;
    logic       b_fire;

    assign bresp_o = '0;
    assign rresp_o = '0;

    // Ready or valid raised three times in four
    function logic coin();
        coin = ($random(seed) & 3) != 0;
    endfunction

    initial begin
        seed      = 32'h857eb164;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
        rlast_o   = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
    end

    // Handshakes are taken on the rising edge
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_left <= '0;
            r_fire  <= 1'b0;
            w_pend  <= 1'b0;
            b_pend  <= 1'b0;
            b_fire  <= 1'b0;
        end else begin
            r_fire <= rvalid_o && rready_i;
            b_fire <= bvalid_o && bready_i;
            if (arvalid_i && arready_o) begin
                rd_addr <= araddr_i[11:2];
                rd_left <= arlen_i + 9'd1;
            end else if (rvalid_o && rready_i) begin
                rd_addr <= rd_addr + 1'b1;
                rd_left <= rd_left - 1'b1;
            end
            if (awvalid_i && awready_o) begin
                wr_addr <= awaddr_i[11:2];
                w_pend  <= 1'b1;
            end
            if (wvalid_i && wready_o) begin
                for (int b = 0; b < `AXI_STRB_BITS; b++) begin
                    if (wstrb_i[b]) begin
                        mem[wr_addr][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
                w_pend <= 1'b0;
                b_pend <= 1'b1;
            end
            if (bvalid_o && bready_i) begin
                b_pend <= 1'b0;
            end
        end
    end

    // Outputs change on the falling edge, a valid holds until taken
    always @(negedge clk) begin
        if (!rst) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
        end else begin
            arready_o <= (rd_left == 0) && coin();
            if (!(rvalid_o && !r_fire)) begin
                rvalid_o <= (rd_left != 0) && coin();
            end
            rdata_o   <= mem[rd_addr];
            rlast_o   <= rd_left == 1;
            awready_o <= !w_pend && !b_pend && coin();
            wready_o  <= w_pend && coin();
            if (!(bvalid_o && !b_fire)) begin
                bvalid_o <= b_pend && coin();
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_mem_sys.sv
`default_nettype none

`include "mem_sys_params.svh"

module tb_mem_sys
    import mem_sys_pkg::*;
();

    localparam int PERIOD       = 20;
    // Reads and writes issued, counting each readback
    localparam int NUM_ACCESSES = 152;

    logic                        clk;
    logic                        rst;
    logic                        req_i;
    logic                        we_i;
    logic [`DATA_BITS-1:0]       addr_i;
    logic [`DATA_BITS-1:0]       wdata_i;
    access_size_e                size_i;
    wire  [`DATA_BITS-1:0]       rdata_o;
    wire                         stall_o;

    wire                         awvalid_o, awready_i, wvalid_o, wready_i, wlast_o;
    wire                         bvalid_i, bready_o, arvalid_o, arready_i;
    wire                         rvalid_i, rready_o, rlast_i;
    wire [`DATA_BITS-1:0]        awaddr_o, araddr_o, wdata_o, rdata_i;
    wire [`AXI_LEN_BITS-1:0]     awlen_o, arlen_o;
    wire [2:0]                   awsize_o, arsize_o;
    wire [1:0]                   awburst_o, arburst_o;
    wire [`AXI_ID_BITS-1:0]      awid_o, arid_o;
    wire [`AXI_STRB_BITS-1:0]    wstrb_o;
    wire [`AXI_RESP_BITS-1:0]    bresp_i, rresp_i;

    logic [`DATA_BITS-1:0]       golden [1024];
    integer                      seed;
    int                          ar_count;
    int                          aw_count;
    int                          w_count;
    logic [`AXI_LEN_BITS-1:0]    last_arlen;
    logic [`DATA_BITS-1:0]       last_araddr;
    logic [`AXI_STRB_BITS-1:0]   last_wstrb;

    mem_sys_top DUT (.*);

    axi_mem_model mem_model (
        .clk(clk), .rst(rst),
        .awvalid_i(awvalid_o), .awready_o(awready_i), .awaddr_i(awaddr_o),
        .wvalid_i(wvalid_o), .wready_o(wready_i), .wdata_i(wdata_o), .wstrb_i(wstrb_o),
        .bvalid_o(bvalid_i), .bready_i(bready_o), .bresp_o(bresp_i),
        .arvalid_i(arvalid_o), .arready_o(arready_i), .araddr_i(araddr_o),
        .arlen_i(arlen_o), .rvalid_o(rvalid_i), .rready_i(rready_o),
        .rdata_o(rdata_i), .rlast_o(rlast_i), .rresp_o(rresp_i)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else
            fail_now($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    // Byte lanes from size and address offset
    function automatic logic [3:0] expected_strobe(access_size_e size, logic [1:0] ofs);
        if (size == SIZE_BYTE) begin
            return 4'b0001 << ofs;
        end else if (size == SIZE_HALF) begin
            return ofs[1] ? 4'b1100 : 4'b0011;
        end
        return 4'b1111;
    endfunction

    // AXI transfer counters and fixed request fields
    always @(posedge clk) begin
        if (arvalid_o && arready_i) begin
            ar_count    <= ar_count + 1;
            last_arlen  <= arlen_o;
            last_araddr <= araddr_o;
            check_value("arsize", `AXI_SIZE_WORD, arsize_o);
            check_value("arburst", `AXI_BURST_INCR, arburst_o);
            check_value("arid", 0, arid_o);
        end
        if (awvalid_o && awready_i) begin
            aw_count <= aw_count + 1;
            check_value("awlen", `AXI_LEN_ONE, awlen_o);
            check_value("awsize", `AXI_SIZE_WORD, awsize_o);
            check_value("awburst", `AXI_BURST_INCR, awburst_o);
            check_value("awid", 0, awid_o);
        end
        if (wvalid_o && wready_i) begin
            w_count    <= w_count + 1;
            last_wstrb <= wstrb_o;
            check_value("wlast", 1, wlast_o);
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !rst |-> !(stall_o || arvalid_o || awvalid_o || wvalid_o || rready_o || bready_o))
        else fail_now("Stall or an AXI valid or ready was high during reset");

    ar_held: assert property (@(posedge clk) disable iff (!rst)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else fail_now("ARVALID or ARADDR changed before ARREADY");

    aw_held: assert property (@(posedge clk) disable iff (!rst)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else fail_now("AWVALID or AWADDR changed before AWREADY");

    w_held: assert property (@(posedge clk) disable iff (!rst)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wstrb_o))
        else fail_now("WVALID or write data changed before WREADY");

    task automatic run_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] data, input access_size_e size,
                              output logic [31:0] rdata, output logic first_stall);
        @(negedge clk);
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        wdata_i = data;
        size_i  = size;
        #1;
        first_stall = stall_o;
        while (stall_o) begin
            @(negedge clk);
            #1;
        end
        rdata = rdata_o;
        @(negedge clk);
        req_i = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [31:0] addr,
                              output logic first_stall);
        logic [31:0] rdata;
        run_access(1'b0, addr, '0, SIZE_WORD, rdata, first_stall);
        check_value(name, golden[addr[11:2]], rdata);
    endtask

    task automatic write_check(input string name, input logic [31:0] addr,
                               input logic [31:0] data, input access_size_e size);
        logic [31:0] rdata;
        logic        stall;
        logic [3:0]  strb;
        logic [31:0] lane_data;
        int          aw0;
        int          w0;
        aw0       = aw_count;
        w0        = w_count;
        strb      = expected_strobe(size, addr[1:0]);
        lane_data = data << (8 * addr[1:0]);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                golden[addr[11:2]][8*b +: 8] = lane_data[8*b +: 8];
            end
        end
        run_access(1'b1, addr, data, size, rdata, stall);
        check_value({name, " aw count"}, aw0 + 1, aw_count);
        check_value({name, " w count"}, w0 + 1, w_count);
        check_value({name, " wstrb"}, strb, last_wstrb);
        check_value({name, " memory"}, golden[addr[11:2]], mem_model.mem[addr[11:2]]);
        read_check({name, " readback"}, {addr[31:2], 2'b00}, stall);
    endtask

    initial begin
        #(PERIOD * (16 + 200 * NUM_ACCESSES));
        fail_now("Watchdog timeout, the accesses did not finish in time");
    end

    initial begin
        logic        stall;
        logic [31:0] addr;
        logic [31:0] r;
        int          ar0;
        access_size_e size;
        seed     = 32'h857eb164;
        ar_count = 0;
        aw_count = 0;
        w_count  = 0;
        rst      = 1'b0;
        req_i    = 1'b0;
        we_i     = 1'b0;
        addr_i   = '0;
        wdata_i  = '0;
        size_i   = SIZE_WORD;
        for (int i = 0; i < 1024; i++) begin
            golden[i]        = (i * 32'h9e3779b1) ^ 32'h5a5a0000 ^ i;
            mem_model.mem[i] = golden[i];
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        #1;
        check_value("stall after reset", 0, stall_o);
        check_value("arvalid after reset", 0, arvalid_o);
        check_value("awvalid after reset", 0, awvalid_o);

        // Each miss fills a line and the second word then hits
        for (int k = 0; k < 8; k++) begin
            addr = k * 32'h50;
            ar0  = ar_count;
            read_check("cached miss", addr, stall);
            check_value("miss ar count", ar0 + 1, ar_count);
            check_value("miss arlen", `AXI_LEN_FOUR, last_arlen);
            check_value("miss araddr", addr & ~32'hf, last_araddr);
            read_check("cached hit", addr ^ 32'h4, stall);
            check_value("hit first stall", 0, stall);
            check_value("hit ar count", ar0 + 1, ar_count);
        end
        // Same index under another tag
        ar0 = ar_count;
        read_check("conflict miss", 32'h400, stall);
        read_check("conflict refill", 32'h0, stall);
        check_value("conflict ar count", ar0 + 2, ar_count);

        // Uncached reads are never allocated
        for (int k = 0; k < 2; k++) begin
            ar0 = ar_count;
            read_check("uncached read", 32'h8000_0124, stall);
            check_value("uncached ar count", ar0 + 1, ar_count);
            check_value("uncached arlen", `AXI_LEN_ONE, last_arlen);
            check_value("uncached araddr", 32'h8000_0124, last_araddr);
        end

        write_check("byte write hit", 32'h51, 32'h0000_00a7, SIZE_BYTE);
        write_check("half write hit", 32'ha2, 32'h0000_c3d4, SIZE_HALF);
        write_check("word write hit", 32'hf0, 32'h1234_5678, SIZE_WORD);
        write_check("byte write miss", 32'h303, 32'h0000_005e, SIZE_BYTE);
        write_check("half write uncached", 32'h8000_0206, 32'h0000_beef, SIZE_HALF);
        write_check("word write miss", 32'h404, 32'hcafe_f00d, SIZE_WORD);

        // Random mix under random back-pressure
        for (int n = 0; n < 60; n++) begin
            r    = $random(seed);
            size = (r[2:1] == 2'd0) ? SIZE_BYTE : (r[2:1] == 2'd1) ? SIZE_HALF : SIZE_WORD;
            addr = $random(seed) & 32'hffc;
            if (size == SIZE_BYTE) begin
                addr[1:0] = r[6:5];
            end else if (size == SIZE_HALF) begin
                addr[1] = r[5];
            end
            if (r[3] && r[4]) begin
                addr[`UNCACHED_BIT] = 1'b1;
            end
            if (r[0]) begin
                write_check("random write", addr, $random(seed), size);
            end else begin
                read_check("random read", {addr[31:2], 2'b00}, stall);
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/mem_sys_pkg.sv
src/cache_bus_if.sv
src/dcache.sv
src/axi_master.sv
src/mem_sys_top.sv
tb/axi_mem_model.sv
tb/tb_mem_sys.sv

// File: Bender.yml
package:
  name: mem_sys

sources:
  - include_dirs:
      - src
    files:
      - src/mem_sys_pkg.sv
      - src/cache_bus_if.sv
      - src/dcache.sv
      - src/axi_master.sv
      - src/mem_sys_top.sv
  - target: any(test, simulation)
    include_dirs:
      - src
    files:
      - tb/axi_mem_model.sv
      - tb/tb_mem_sys.sv
